// File: acc_config.svh
`ifndef ACC_CONFIG_SVH
`define ACC_CONFIG_SVH

// ============================================================
// Datapath sizing
// ============================================================

// Partial sum and bank word width
`define ACC_DW          16

// Output memory organisation
`define ACC_NUM_BANKS   16
`define ACC_BANK_DEPTH  512

// Processing array columns feeding the accumulator
`define ACC_NUM_COLS    16

// ============================================================
// Derived widths
// ============================================================

// Bank number, 4 bits for 16 banks
`define ACC_SEL_W       $clog2(`ACC_NUM_BANKS)

// Word address inside one bank, 9 bits for 512 words
`define ACC_ADDR_W      $clog2(`ACC_BANK_DEPTH)

// Column index
`define ACC_COL_W       $clog2(`ACC_NUM_COLS)

// All bank read ports side by side
`define ACC_FLAT_W      (`ACC_NUM_BANKS * `ACC_DW)

// Pipeline depth from accepted hit to memory update
`define ACC_PIPE_DEPTH  6

`endif

// File: acc_data_pkg.sv
`include "acc_config.svh"

package acc_data_pkg;

    // ============================================================
    // Scalar datapath types
    // ============================================================

    // Signed partial sum, also the accumulated bank word
    typedef logic signed [`ACC_DW-1:0] psum_t;

    // Which output bank a hit goes to
    typedef logic [`ACC_SEL_W-1:0] bank_sel_t;

    // Word address within that bank
    typedef logic [`ACC_ADDR_W-1:0] bank_addr_t;

    // Flattened read data of every bank
    typedef logic [`ACC_FLAT_W-1:0] bank_flat_t;

    // One-hot write enables over the banks
    typedef logic [`ACC_NUM_BANKS-1:0] bank_mask_t;

    // ============================================================
    // Item carried between pipeline stages
    // ============================================================

    // rdata stays zero until the read data is captured in stage 4;
    // after stage 5 psum holds the new sum
    typedef struct packed {
        logic       valid;
        bank_sel_t  bank;
        bank_addr_t addr;
        psum_t      psum;
        psum_t      rdata;
    } acc_stage_t;

endpackage

// File: acc_map_pkg.sv
`include "acc_config.svh"

package acc_map_pkg;

    // ============================================================
    // Column mapping
    // ============================================================

    // Processing array column index
    typedef logic [`ACC_COL_W-1:0] col_id_t;

    // One column map register
    // Inactive columns drop their partial sums
    typedef struct packed {
        logic                     active;
        acc_data_pkg::bank_sel_t  bank;
        acc_data_pkg::bank_addr_t addr;
    } col_map_entry_t;

endpackage

// File: col_map_table.sv
`timescale 1ns/1ps

`include "acc_config.svh"

module col_map_table (
    input  logic                        clk,
    input  logic                        rst_n,

    // Map register write port
    input  logic                        cfg_we,
    input  acc_map_pkg::col_id_t        cfg_col,
    input  acc_map_pkg::col_map_entry_t cfg_entry,

    // Partial sums from the processing array
    input  logic                        partial_valid,
    input  acc_data_pkg::psum_t         partial_in,
    input  acc_map_pkg::col_id_t        col_id,

    output acc_data_pkg::acc_stage_t    s1
);

    acc_map_pkg::col_map_entry_t map_q [`ACC_NUM_COLS];
    acc_map_pkg::col_map_entry_t entry;
    acc_data_pkg::acc_stage_t    s1_next;
    logic                        hit;

    // ============================================================
    // Map registers, all columns inactive out of reset
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ACC_NUM_COLS; i++) begin
                map_q[i] <= '0;
            end
        end else if (cfg_we) begin
            map_q[cfg_col] <= cfg_entry;
        end
    end

    // ============================================================
    // Stage 1: lookup and filter
    // ============================================================
    always_comb begin
        entry           = map_q[col_id];
        hit             = partial_valid && entry.active;
        s1_next         = '0;
        s1_next.valid   = hit;
        s1_next.psum    = partial_in;
        // Dropped items carry bank and address zero
        if (hit) begin
            s1_next.bank = entry.bank;
            s1_next.addr = entry.addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
        end else begin
            s1 <= s1_next;
        end
    end

endmodule

// File: acc_read_stage.sv
`timescale 1ns/1ps

`include "acc_config.svh"

module acc_read_stage (
    input  logic                       clk,
    input  logic                       rst_n,

    input  acc_data_pkg::acc_stage_t   s1,

    // Accumulate read port of the bank array
    output acc_data_pkg::bank_sel_t    rd_bank,
    output acc_data_pkg::bank_addr_t   rd_addr,
    input  acc_data_pkg::bank_flat_t   rd_data_flat,

    output acc_data_pkg::acc_stage_t   s4
);

    acc_data_pkg::acc_stage_t s2;
    acc_data_pkg::acc_stage_t s3;
    acc_data_pkg::psum_t      sel_word;

    // ============================================================
    // Stage 2: issue the bank read
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2      <= '0;
            rd_bank <= '0;
            rd_addr <= '0;
        end else begin
            s2 <= s1;
            // Read port holds its last address between hits
            if (s1.valid) begin
                rd_bank <= s1.bank;
                rd_addr <= s1.addr;
            end
        end
    end

    // ============================================================
    // Stage 3: wait out the registered memory read
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s3 <= '0;
        end else begin
            s3 <= s2;
        end
    end

    // ============================================================
    // Stage 4: capture the addressed bank's word
    // ============================================================
    assign sel_word = rd_data_flat[s3.bank*`ACC_DW +: `ACC_DW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s4 <= '0;
        end else begin
            s4       <= s3;
            s4.rdata <= s3.valid ? sel_word : '0;
        end
    end

endmodule

// File: acc_update_stage.sv
`timescale 1ns/1ps

`include "acc_config.svh"

module acc_update_stage (
    input  logic                       clk,
    input  logic                       rst_n,

    input  acc_data_pkg::acc_stage_t   s4,

    // Accumulate write port of the bank array
    output acc_data_pkg::bank_mask_t   wr_en,
    output acc_data_pkg::bank_addr_t   wr_addr,
    output acc_data_pkg::psum_t        wr_data,

    // Valid flags of stages 5 and 6
    output logic [1:0]                 stage_busy
);

    acc_data_pkg::acc_stage_t s5;
    acc_data_pkg::bank_mask_t wr_onehot;
    logic                     valid_s6;

    // ============================================================
    // Stage 5: accumulate, wraps at ACC_DW bits
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s5 <= '0;
        end else begin
            s5.valid <= s4.valid;
            s5.bank  <= s4.bank;
            s5.addr  <= s4.addr;
            s5.psum  <= s4.valid ? acc_data_pkg::psum_t'(s4.psum + s4.rdata) : '0;
            s5.rdata <= '0;
        end
    end

    // ============================================================
    // Stage 6: one-hot bank write
    // ============================================================
    always_comb begin
        for (int b = 0; b < `ACC_NUM_BANKS; b++) begin
            wr_onehot[b] = s5.valid && (s5.bank == b);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en    <= '0;
            wr_addr  <= '0;
            wr_data  <= '0;
            valid_s6 <= 1'b0;
        end else begin
            wr_en    <= wr_onehot;
            wr_addr  <= s5.addr;
            wr_data  <= s5.psum;
            valid_s6 <= s5.valid;
        end
    end

    assign stage_busy = {valid_s6, s5.valid};

endmodule

// File: output_bank_array.sv
`timescale 1ns/1ps

`include "acc_config.svh"

module output_bank_array (
    input  logic                       clk,
    input  logic                       rst_n,

    // Accumulate read port
    input  acc_data_pkg::bank_sel_t    rd_bank,
    input  acc_data_pkg::bank_addr_t   rd_addr,
    output acc_data_pkg::bank_flat_t   rd_data_flat,

    // Accumulate write port
    input  acc_data_pkg::bank_mask_t   wr_en,
    input  acc_data_pkg::bank_addr_t   wr_addr,
    input  acc_data_pkg::psum_t        wr_data,

    // Drain port
    input  logic                       drain_en,
    input  acc_data_pkg::bank_sel_t    drain_bank,
    input  acc_data_pkg::bank_addr_t   drain_addr,
    input  logic                       drain_clear,
    output acc_data_pkg::psum_t        drain_data,
    output logic                       drain_valid
);

    acc_data_pkg::bank_mask_t bank_re;
    acc_data_pkg::bank_mask_t bank_we;
    acc_data_pkg::bank_addr_t bank_rd_addr;
    acc_data_pkg::bank_addr_t bank_wr_addr;
    acc_data_pkg::psum_t      bank_wr_data;

    // Drain request held for its second cycle
    logic                     drain_pend;
    logic                     clr_pend;
    acc_data_pkg::bank_sel_t  drain_bank_q;
    acc_data_pkg::bank_addr_t drain_addr_q;

    // ============================================================
    // Port sharing
    // ============================================================
    always_comb begin
        // Drain borrows the read path, only allowed while idle
        bank_rd_addr = drain_en ? drain_addr : rd_addr;
        for (int b = 0; b < `ACC_NUM_BANKS; b++) begin
            bank_re[b] = drain_en ? (drain_bank == b) : (rd_bank == b);
            bank_we[b] = wr_en[b] || (clr_pend && (drain_bank_q == b));
        end
        // Clear goes through the write port one cycle after the read
        bank_wr_addr = clr_pend ? drain_addr_q : wr_addr;
        bank_wr_data = clr_pend ? '0 : wr_data;
    end

    // ============================================================
    // Banks, one registered read each
    // ============================================================
    for (genvar b = 0; b < `ACC_NUM_BANKS; b++) begin : g_bank
        acc_data_pkg::psum_t mem [`ACC_BANK_DEPTH];
        acc_data_pkg::psum_t rd_q;

        always_ff @(posedge clk) begin
            if (bank_we[b]) begin
                mem[bank_wr_addr] <= bank_wr_data;
            end
            if (bank_re[b]) begin
                rd_q <= mem[bank_rd_addr];
            end
        end

        assign rd_data_flat[b*`ACC_DW +: `ACC_DW] = rd_q;
    end

    // ============================================================
    // Drain output, second register stage
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_pend  <= 1'b0;
            clr_pend    <= 1'b0;
            drain_valid <= 1'b0;
        end else begin
            drain_pend  <= drain_en;
            clr_pend    <= drain_en && drain_clear;
            drain_valid <= drain_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (drain_en) begin
            drain_bank_q <= drain_bank;
            drain_addr_q <= drain_addr;
        end
        drain_data <= rd_data_flat[drain_bank_q*`ACC_DW +: `ACC_DW];
    end

endmodule

// File: psum_accumulator.sv
`timescale 1ns/1ps

`include "acc_config.svh"

module psum_accumulator (
    input  logic                        clk,
    input  logic                        rst_n,

    // Processing array input
    input  logic                        partial_valid,
    input  acc_data_pkg::psum_t         partial_in,
    input  acc_map_pkg::col_id_t        col_id,

    // Column map configuration
    input  logic                        cfg_we,
    input  acc_map_pkg::col_id_t        cfg_col,
    input  acc_map_pkg::col_map_entry_t cfg_entry,

    // Result drain
    input  logic                        drain_en,
    input  acc_data_pkg::bank_sel_t     drain_bank,
    input  acc_data_pkg::bank_addr_t    drain_addr,
    input  logic                        drain_clear,
    output logic                        drain_valid,
    output acc_data_pkg::psum_t         drain_data,

    output logic                        busy
);

    acc_data_pkg::acc_stage_t s1;
    acc_data_pkg::acc_stage_t s4;
    acc_data_pkg::bank_sel_t  rd_bank;
    acc_data_pkg::bank_addr_t rd_addr;
    acc_data_pkg::bank_flat_t rd_data_flat;
    acc_data_pkg::bank_mask_t wr_en;
    acc_data_pkg::bank_addr_t wr_addr;
    acc_data_pkg::psum_t      wr_data;
    logic [1:0]               stage_busy;
    logic [1:0]               mid_valid;

    // ============================================================
    // Pipeline and memory
    // ============================================================
    col_map_table map_i (
        .clk, .rst_n, .cfg_we, .cfg_col, .cfg_entry,
        .partial_valid, .partial_in, .col_id, .s1
    );

    acc_read_stage read_i (
        .clk, .rst_n, .s1, .rd_bank, .rd_addr, .rd_data_flat, .s4
    );

    acc_update_stage update_i (
        .clk, .rst_n, .s4, .wr_en, .wr_addr, .wr_data, .stage_busy
    );

    output_bank_array banks_i (
        .clk, .rst_n, .rd_bank, .rd_addr, .rd_data_flat,
        .wr_en, .wr_addr, .wr_data,
        .drain_en, .drain_bank, .drain_addr, .drain_clear,
        .drain_data, .drain_valid
    );

    // ============================================================
    // Busy
    // ============================================================

    // Tracks the valid flags of stages 2 and 3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_valid <= '0;
        end else begin
            mid_valid <= {mid_valid[0], s1.valid};
        end
    end

    assign busy = s1.valid || (|mid_valid) || s4.valid || (|stage_busy);

endmodule

// File: tb_psum_accumulator.sv
`timescale 1ns/1ps

`include "acc_config.svh"

module tb_psum_accumulator;

    localparam int CLK_HALF_NS   = 10;
    localparam int RESET_CYCLES  = 2;
    localparam int IDLE_TIMEOUT  = 2 * `ACC_PIPE_DEPTH;
    localparam int DRAIN_TIMEOUT = 6;
    localparam int RAND_HITS     = 10;
    // Cycle budget per operation and how often each one runs
    localparam int HIT_COST      = 3 + IDLE_TIMEOUT + 3;
    localparam int DRAIN_COST    = 2 + DRAIN_TIMEOUT;
    localparam int SPACED_HITS   = 16 + 1 + (RAND_HITS + 2) + 8;
    localparam int BURST_HITS    = 2 * `ACC_NUM_COLS;
    localparam int DRAINS        = 45;
    localparam int CONFIGS       = 21;
    localparam int TEST_CYCLES   = RESET_CYCLES + SPACED_HITS * HIT_COST + BURST_HITS
                                 + IDLE_TIMEOUT + DRAINS * DRAIN_COST + CONFIGS * 2;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + 200) * 2 * CLK_HALF_NS;

    logic                        clk;
    logic                        rst_n;
    logic                        partial_valid;
    acc_data_pkg::psum_t         partial_in;
    acc_map_pkg::col_id_t        col_id;
    logic                        cfg_we;
    acc_map_pkg::col_id_t        cfg_col;
    acc_map_pkg::col_map_entry_t cfg_entry;
    logic                        drain_en;
    acc_data_pkg::bank_sel_t     drain_bank;
    acc_data_pkg::bank_addr_t    drain_addr;
    logic                        drain_clear;
    logic                        drain_valid;
    acc_data_pkg::psum_t         drain_data;
    logic                        busy;

    // Expected drain result held until the next request
    acc_data_pkg::psum_t         drain_expect;
    logic                        drain_check;

    // High while every column is still inactive
    logic                        write_forbidden;

    acc_data_pkg::psum_t         model_mem [`ACC_NUM_BANKS][`ACC_BANK_DEPTH];
    acc_map_pkg::col_map_entry_t map_model [`ACC_NUM_COLS];
    string                       test_name;
    int                          value_errors;
    int                          other_errors;
    integer                      seed;

    psum_accumulator dut_i (
        .clk, .rst_n, .partial_valid, .partial_in, .col_id,
        .cfg_we, .cfg_col, .cfg_entry,
        .drain_en, .drain_bank, .drain_addr, .drain_clear,
        .drain_valid, .drain_data, .busy
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF_NS) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    // ============================================================
    // Assertions
    // ============================================================
    drain_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        drain_valid == $past(drain_en, 2))
    else begin
        other_errors++;
        $display("%s: drain_valid does not follow drain_en by two cycles", test_name);
    end

    drain_data_a: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(drain_en, 2) && drain_check) |-> (drain_data == drain_expect))
    else begin
        value_errors++;
        $display("error %s expected %0d actual %0d",
                 test_name, $sampled(drain_expect), $sampled(drain_data));
    end

    unmapped_no_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        write_forbidden |-> (dut_i.wr_en == '0))
    else begin
        other_errors++;
        $display("%s: bank write while no column is active", test_name);
    end

    // ============================================================
    // Reference model and stimulus tasks
    // ============================================================
    function automatic void model_hit(input acc_map_pkg::col_id_t col,
                                      input acc_data_pkg::psum_t value);
        acc_map_pkg::col_map_entry_t e;
        e = map_model[col];
        if (e.active) begin
            model_mem[e.bank][e.addr] = model_mem[e.bank][e.addr] + value;
        end
    endfunction

    task automatic configure(input acc_map_pkg::col_id_t col, input logic active,
                             input acc_data_pkg::bank_sel_t bank,
                             input acc_data_pkg::bank_addr_t addr);
        acc_map_pkg::col_map_entry_t e;
        e.active = active;
        e.bank   = bank;
        e.addr   = addr;
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_col   <= col;
        cfg_entry <= e;
        map_model[col] = e;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic send_hit(input acc_map_pkg::col_id_t col, input acc_data_pkg::psum_t value);
        logic accepted;
        accepted = map_model[col].active;
        @(posedge clk);
        partial_valid <= 1'b1;
        col_id        <= col;
        partial_in    <= value;
        @(posedge clk);
        partial_valid <= 1'b0;
        model_hit(col, value);
        @(negedge clk);
        assert (busy == accepted) else begin
            value_errors++;
            $display("error %s expected busy %0b actual %0b", test_name, accepted, busy);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (busy && n < IDLE_TIMEOUT);
        if (busy) begin
            other_errors++;
            $display("%s: pipeline still busy after %0d cycles", test_name, n);
        end
    endtask

    task automatic drain_word(input acc_data_pkg::bank_sel_t bank,
                              input acc_data_pkg::bank_addr_t addr,
                              input logic clear, input logic check);
        int lat;
        @(posedge clk);
        drain_en     <= 1'b1;
        drain_bank   <= bank;
        drain_addr   <= addr;
        drain_clear  <= clear;
        drain_check  <= check;
        drain_expect <= model_mem[bank][addr];
        if (clear) begin
            model_mem[bank][addr] = '0;
        end
        @(posedge clk);
        drain_en    <= 1'b0;
        drain_clear <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!drain_valid && lat < DRAIN_TIMEOUT);
        if (!drain_valid) begin
            other_errors++;
            $display("%s: no drain_valid within %0d cycles", test_name, lat);
        end else begin
            assert (lat == 2) else begin
                value_errors++;
                $display("error %s expected latency 2 actual %0d", test_name, lat);
            end
        end
    endtask

    // Two rounds over all columns with a new hit every cycle
    task automatic run_burst();
        acc_data_pkg::psum_t v;
        for (int i = 0; i < BURST_HITS; i++) begin
            @(posedge clk);
            v = acc_data_pkg::psum_t'($random(seed));
            partial_valid <= 1'b1;
            col_id        <= acc_map_pkg::col_id_t'(i);
            partial_in    <= v;
            model_hit(acc_map_pkg::col_id_t'(i), v);
            @(negedge clk);
            if (i > 0) begin
                assert (busy) else begin
                    value_errors++;
                    $display("error %s expected busy 1 actual 0", test_name);
                end
            end
        end
        @(posedge clk);
        partial_valid <= 1'b0;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int gap;
        seed            = 32'hdaee;
        value_errors    = 0;
        other_errors    = 0;
        test_name       = "reset";
        rst_n           = 1'b0;
        partial_valid   = 1'b0;
        partial_in      = '0;
        col_id          = '0;
        cfg_we          = 1'b0;
        cfg_col         = '0;
        cfg_entry       = '0;
        drain_en        = 1'b0;
        drain_bank      = '0;
        drain_addr      = '0;
        drain_clear     = 1'b0;
        drain_check     = 1'b0;
        drain_expect    = '0;
        write_forbidden = 1'b1;
        for (int c = 0; c < `ACC_NUM_COLS; c++) begin
            map_model[c] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Unconfigured columns all point at bank 0 word 0
        test_name = "reset_idle";
        @(negedge clk);
        assert (!busy && !drain_valid && dut_i.wr_en == '0) else begin
            other_errors++;
            $display("%s: busy, drain_valid or a write active after reset", test_name);
        end
        drain_word(0, 0, 1'b1, 1'b0);
        for (int c = 0; c < `ACC_NUM_COLS; c++) begin
            send_hit(acc_map_pkg::col_id_t'(c), acc_data_pkg::psum_t'($random(seed)));
        end
        drain_word(0, 0, 1'b0, 1'b1);

        test_name = "single_value";
        configure(5, 1'b1, 7, 9'h1a3);
        drain_word(7, 9'h1a3, 1'b1, 1'b0);
        write_forbidden = 1'b0;
        send_hit(5, acc_data_pkg::psum_t'($random(seed)));
        wait_idle();
        drain_word(7, 9'h1a3, 1'b1, 1'b1);
        drain_word(7, 9'h1a3, 1'b0, 1'b1);

        // Second hit pushes the word past the largest positive value
        test_name = "wrap_sum";
        configure(9, 1'b1, 12, 9'h0ff);
        drain_word(12, 9'h0ff, 1'b1, 1'b0);
        send_hit(9, 16'sh7ff0);
        wait_idle();
        send_hit(9, 16'sh0100);
        wait_idle();
        for (int i = 0; i < RAND_HITS; i++) begin
            send_hit(9, acc_data_pkg::psum_t'($random(seed)));
            wait_idle();
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end
        drain_word(12, 9'h0ff, 1'b0, 1'b1);

        test_name = "inactive_column";
        configure(2, 1'b1, 1, 9'h010);
        configure(3, 1'b1, 2, 9'h020);
        drain_word(1, 9'h010, 1'b1, 1'b0);
        drain_word(2, 9'h020, 1'b1, 1'b0);
        send_hit(2, acc_data_pkg::psum_t'($random(seed)));
        wait_idle();
        send_hit(3, acc_data_pkg::psum_t'($random(seed)));
        wait_idle();
        configure(2, 1'b0, 1, 9'h010);
        for (int i = 0; i < 3; i++) begin
            send_hit(2, acc_data_pkg::psum_t'($random(seed)));
            wait_idle();
            send_hit(3, acc_data_pkg::psum_t'($random(seed)));
            wait_idle();
        end
        drain_word(1, 9'h010, 1'b0, 1'b1);
        drain_word(2, 9'h020, 1'b0, 1'b1);

        // Column c feeds bank 15-c so every pair is distinct
        test_name = "burst";
        for (int c = 0; c < `ACC_NUM_COLS; c++) begin
            configure(acc_map_pkg::col_id_t'(c), 1'b1, acc_data_pkg::bank_sel_t'(15 - c),
                      acc_data_pkg::bank_addr_t'(c * 29 + 3));
            drain_word(acc_data_pkg::bank_sel_t'(15 - c),
                       acc_data_pkg::bank_addr_t'(c * 29 + 3), 1'b1, 1'b0);
        end
        run_burst();
        wait_idle();
        for (int c = 0; c < `ACC_NUM_COLS; c++) begin
            drain_word(acc_data_pkg::bank_sel_t'(15 - c),
                       acc_data_pkg::bank_addr_t'(c * 29 + 3), 1'b0, 1'b1);
        end

        test_name = "drain_latency";
        drain_word(15, 9'd3, 1'b1, 1'b1);
        drain_word(15, 9'd3, 1'b0, 1'b1);

        repeat (4) @(posedge clk);
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: psum_accumulator.f
+incdir+.
acc_data_pkg.sv
acc_map_pkg.sv
col_map_table.sv
acc_read_stage.sv
acc_update_stage.sv
output_bank_array.sv
psum_accumulator.sv
tb_psum_accumulator.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_psum_accumulator
FILELIST  := psum_accumulator.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS   := acc_config.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the testbench printed the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
